// File: verilog/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// architectural registers of RV32E.
`define EXU_NREG 16

// entries kept in the forwarding history.
`define EXU_BYPASS_DEPTH 4

// data memory depth in 32-bit words.
`define EXU_DMEM_WORDS 256

`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341

`endif

// File: verilog/exu_pkg.sv
package exu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // branch opcodes only compare, the target comes from pc + imm.
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    typedef enum logic [3:0] {
        UOP_ALU,
        UOP_BRANCH,
        UOP_JUMP,
        UOP_LOAD,
        UOP_STORE,
        UOP_CSRRW,
        UOP_CSRRS,
        UOP_ECALL,
        UOP_MRET,
        UOP_EBREAK
    } uop_class_e;

    // csr ops carry the csr address in imm[11:0].
    typedef struct packed {
        uop_class_e uop_class;
        alu_op_e    alu_op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        word_t      pc;
        logic       src1_is_pc;
        logic       src2_is_imm;
        logic       gpr_we;
        logic       load_signed;
        mem_size_e  mem_size;
    } uop_t;

    typedef enum logic {
        WB_KIND_WB,
        WB_KIND_REDIRECT
    } wb_kind_e;

endpackage

// File: verilog/exu_if.sv
`timescale 1ns/1ps

// execute to load/store unit, one registered micro-op per cycle.
interface ex_mem_if;
    logic               valid;
    exu_pkg::reg_idx_t  rd;
    logic               gpr_we;
    logic               is_load;
    logic               is_store;
    logic               load_signed;
    exu_pkg::mem_size_e size;
    exu_pkg::word_t     addr;
    exu_pkg::word_t     store_data;
    exu_pkg::word_t     result;

    modport exu_side (output valid, rd, gpr_we, is_load, is_store, load_signed,
                      size, addr, store_data, result);
    modport lsu_side (input valid, rd, gpr_we, is_load, is_store, load_signed,
                      size, addr, store_data, result);
endinterface

interface wb_if;
    logic              valid;
    exu_pkg::reg_idx_t rd;
    exu_pkg::word_t    data;
    logic              is_load_return; // set when data comes from the memory read.

    modport producer (output valid, rd, data, is_load_return);
    modport regfile_side (input valid, rd, data);
    modport bypass_side (input valid, rd, data, is_load_return);
endinterface

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  exu_pkg::alu_op_e op,
    input  exu_pkg::word_t   a,
    input  exu_pkg::word_t   b,
    output exu_pkg::word_t   result,
    output logic             cond
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        result = a + b; // branches keep the sum as target.
        cond   = 1'b0;
        case (op)
            exu_pkg::ALU_ADD:  result = a + b;
            exu_pkg::ALU_SUB:  result = a - b;
            exu_pkg::ALU_SLL:  result = a << shamt;
            exu_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            exu_pkg::ALU_SLTU: result = {31'b0, a < b};
            exu_pkg::ALU_XOR:  result = a ^ b;
            exu_pkg::ALU_SRL:  result = a >> shamt;
            exu_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            exu_pkg::ALU_OR:   result = a | b;
            exu_pkg::ALU_AND:  result = a & b;
            exu_pkg::ALU_LUI:  result = b; // the immediate arrives already shifted.
            exu_pkg::ALU_BEQ:  cond = (a == b);
            exu_pkg::ALU_BNE:  cond = (a != b);
            exu_pkg::ALU_BLT:  cond = ($signed(a) < $signed(b));
            exu_pkg::ALU_BGE:  cond = ($signed(a) >= $signed(b));
            exu_pkg::ALU_BLTU: cond = (a < b);
            exu_pkg::ALU_BGEU: cond = (a >= b);
            default: begin
                result = a + b;
                cond   = 1'b0;
            end
        endcase
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  exu_pkg::reg_idx_t rs1_idx,
    input  exu_pkg::reg_idx_t rs2_idx,
    output exu_pkg::word_t    rs1_data,
    output exu_pkg::word_t    rs2_data,
    wb_if.regfile_side        wb
);
    exu_pkg::word_t regs [`EXU_NREG];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `EXU_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 is hardwired.
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// File: verilog/exu.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  exu_pkg::uop_t  in_uop,
    output logic           in_ready,
    input  exu_pkg::word_t rs1_data,
    input  exu_pkg::word_t rs2_data,
    output logic           redirect_valid,
    output exu_pkg::word_t redirect_pc,
    input  logic           redirect_ack,
    output logic           halt,
    ex_mem_if.exu_side     mem,
    wb_if.bypass_side      wb
);
    localparam int DEPTH = `EXU_BYPASS_DEPTH;

    // history index 0 is the newest entry.
    logic              hist_valid [DEPTH];
    exu_pkg::reg_idx_t hist_rd    [DEPTH];
    exu_pkg::word_t    hist_data  [DEPTH];
    logic              hist_pend  [DEPTH];
    exu_pkg::word_t    fill_data  [DEPTH];
    logic              fill_pend  [DEPTH];
    logic              fill_hit;

    exu_pkg::word_t src1;
    exu_pkg::word_t src2;
    logic           src1_pend;
    logic           src2_pend;
    exu_pkg::word_t alu_a;
    exu_pkg::word_t alu_b;
    exu_pkg::word_t alu_result;
    logic           alu_cond;
    exu_pkg::word_t pc_plus4;
    exu_pkg::word_t result;
    exu_pkg::word_t target;
    logic           take;
    logic           live;
    logic           push;
    logic           is_csr;
    exu_pkg::word_t csr_old;
    exu_pkg::word_t csr_new;
    exu_pkg::word_t mstatus;
    exu_pkg::word_t mtvec;
    exu_pkg::word_t mepc;

    function automatic void lookup(input exu_pkg::reg_idx_t idx, input exu_pkg::word_t rf,
                                   output exu_pkg::word_t data, output logic pend);
        logic found;
        found = 1'b0;
        data  = rf;
        pend  = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!found && idx != '0 && hist_valid[i] && hist_rd[i] == idx) begin
                data  = fill_data[i];
                pend  = fill_pend[i];
                found = 1'b1;
            end
        end
    endfunction

    // a returning load fills its entry and is forwarded in the same cycle.
    always_comb begin
        fill_hit = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            fill_data[i] = hist_data[i];
            fill_pend[i] = hist_pend[i];
            if (wb.valid && wb.is_load_return && !fill_hit && hist_valid[i] &&
                hist_pend[i] && hist_rd[i] == wb.rd) begin
                fill_data[i] = wb.data;
                fill_pend[i] = 1'b0;
                fill_hit     = 1'b1;
            end
        end
    end

    always_comb begin
        lookup(in_uop.rs1, rs1_data, src1, src1_pend);
        lookup(in_uop.rs2, rs2_data, src2, src2_pend);
    end

    // the cycle after a load is held so writebacks stay in order.
    assign in_ready = !src1_pend && !src2_pend && !(mem.valid && mem.is_load);
    assign live     = in_valid && in_ready && !redirect_valid;
    assign push     = live && in_uop.gpr_we && in_uop.rd != '0;

    assign alu_a    = in_uop.src1_is_pc ? in_uop.pc : src1;
    assign alu_b    = in_uop.src2_is_imm ? in_uop.imm : src2;
    assign pc_plus4 = in_uop.pc + 32'd4;

    alu u_alu (
        .op     (in_uop.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .cond   (alu_cond)
    );

    assign is_csr  = (in_uop.uop_class == exu_pkg::UOP_CSRRW) ||
                     (in_uop.uop_class == exu_pkg::UOP_CSRRS);
    assign csr_new = (in_uop.uop_class == exu_pkg::UOP_CSRRW) ? src1 : (csr_old | src1);

    always_comb begin
        case (in_uop.imm[11:0])
            `EXU_CSR_MSTATUS: csr_old = mstatus;
            `EXU_CSR_MTVEC:   csr_old = mtvec;
            `EXU_CSR_MEPC:    csr_old = mepc;
            default:          csr_old = '0;
        endcase
    end

    always_comb begin
        take   = 1'b0;
        target = in_uop.pc + in_uop.imm;
        result = alu_result;
        case (in_uop.uop_class)
            exu_pkg::UOP_BRANCH: take = alu_cond;
            exu_pkg::UOP_JUMP: begin
                target = {alu_result[31:1], 1'b0};
                take   = (target != pc_plus4);
                result = pc_plus4;
            end
            exu_pkg::UOP_CSRRW, exu_pkg::UOP_CSRRS: result = csr_old;
            exu_pkg::UOP_ECALL: begin
                take   = 1'b1;
                target = mtvec;
            end
            exu_pkg::UOP_MRET: begin
                take   = 1'b1;
                target = mepc;
            end
            default: take = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
        end else if (live) begin
            if (is_csr) begin
                case (in_uop.imm[11:0])
                    `EXU_CSR_MSTATUS: mstatus <= csr_new;
                    `EXU_CSR_MTVEC:   mtvec <= csr_new;
                    `EXU_CSR_MEPC:    mepc <= csr_new;
                    default:          mstatus <= mstatus;
                endcase
            end
            if (in_uop.uop_class == exu_pkg::UOP_ECALL) begin
                mepc <= in_uop.pc;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            mem.valid      <= 1'b0;
            halt           <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                hist_valid[i] <= 1'b0;
            end
        end else begin
            if (redirect_valid) begin
                redirect_valid <= !redirect_ack; // dropped the cycle after the ack.
            end else if (live && take) begin
                redirect_valid <= 1'b1;
            end
            mem.valid <= live;
            halt      <= live && in_uop.uop_class == exu_pkg::UOP_EBREAK;
            if (push) begin
                for (int i = DEPTH - 1; i > 0; i--) begin
                    hist_valid[i] <= hist_valid[i - 1];
                end
                hist_valid[0] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            hist_data[i] <= fill_data[i];
            hist_pend[i] <= fill_pend[i];
        end
        if (push) begin
            for (int i = DEPTH - 1; i > 0; i--) begin
                hist_rd[i]   <= hist_rd[i - 1];
                hist_data[i] <= fill_data[i - 1];
                hist_pend[i] <= fill_pend[i - 1];
            end
            hist_rd[0]   <= in_uop.rd;
            hist_data[0] <= result;
            hist_pend[0] <= (in_uop.uop_class == exu_pkg::UOP_LOAD);
        end
        if (live && take) begin
            redirect_pc <= target;
        end
        if (live) begin
            mem.rd          <= in_uop.rd;
            mem.gpr_we      <= in_uop.gpr_we;
            mem.is_load     <= (in_uop.uop_class == exu_pkg::UOP_LOAD);
            mem.is_store    <= (in_uop.uop_class == exu_pkg::UOP_STORE);
            mem.load_signed <= in_uop.load_signed;
            mem.size        <= in_uop.mem_size;
            mem.addr        <= alu_result;
            mem.store_data  <= src2;
            mem.result      <= result;
        end
    end

endmodule

// File: verilog/lsu.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module lsu (
    input  logic       clk,
    input  logic       rst,
    ex_mem_if.lsu_side mem,
    wb_if.producer     wb
);
    localparam int AW = $clog2(`EXU_DMEM_WORDS);

    exu_pkg::word_t     dmem [`EXU_DMEM_WORDS];
    logic [AW-1:0]      widx;
    logic [3:0]         lane_en;
    exu_pkg::word_t     wdata;
    exu_pkg::word_t     rdata;
    logic               ld_valid;
    exu_pkg::reg_idx_t  ld_rd;
    logic [1:0]         ld_off;
    exu_pkg::mem_size_e ld_size;
    logic               ld_signed;
    exu_pkg::word_t     ld_shifted;
    exu_pkg::word_t     ld_value;

    assign widx = mem.addr[AW+1:2];

    // store data is replicated so every enabled lane sees its bytes.
    always_comb begin
        case (mem.size)
            exu_pkg::MEM_BYTE: begin
                lane_en = 4'b0001 << mem.addr[1:0];
                wdata   = {4{mem.store_data[7:0]}};
            end
            exu_pkg::MEM_HALF: begin
                lane_en = mem.addr[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{mem.store_data[15:0]}};
            end
            exu_pkg::MEM_WORD: begin
                lane_en = 4'b1111;
                wdata   = mem.store_data;
            end
            default: begin
                lane_en = 4'b0000;
                wdata   = mem.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem.valid && mem.is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) begin
                    dmem[widx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        if (mem.valid && mem.is_load) begin
            rdata     <= dmem[widx];
            ld_rd     <= mem.rd;
            ld_off    <= mem.addr[1:0];
            ld_size   <= mem.size;
            ld_signed <= mem.load_signed;
        end
    end

    assign ld_shifted = rdata >> {ld_off, 3'b000};

    always_comb begin
        case (ld_size)
            exu_pkg::MEM_BYTE:
                ld_value = {{24{ld_signed & ld_shifted[7]}}, ld_shifted[7:0]};
            exu_pkg::MEM_HALF:
                ld_value = {{16{ld_signed & ld_shifted[15]}}, ld_shifted[15:0]};
            default:
                ld_value = ld_shifted;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ld_valid <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            ld_valid <= mem.valid && mem.is_load && mem.gpr_we;
            wb.valid <= ld_valid || (mem.valid && mem.gpr_we && !mem.is_load && !mem.is_store);
        end
    end

    // the exu hold after a load keeps both sources from meeting here.
    always_ff @(posedge clk) begin
        if (ld_valid) begin
            wb.rd             <= ld_rd;
            wb.data           <= ld_value;
            wb.is_load_return <= 1'b1;
        end else begin
            wb.rd             <= mem.rd;
            wb.data           <= mem.result;
            wb.is_load_return <= 1'b0;
        end
    end

endmodule

// File: verilog/exec_core.sv
`timescale 1ns/1ps

module exec_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  exu_pkg::uop_class_e in_class,
    input  exu_pkg::alu_op_e    in_alu_op,
    input  exu_pkg::reg_idx_t   in_rd,
    input  exu_pkg::reg_idx_t   in_rs1,
    input  exu_pkg::reg_idx_t   in_rs2,
    input  exu_pkg::word_t      in_imm,
    input  exu_pkg::word_t      in_pc,
    input  logic                in_src1_is_pc,
    input  logic                in_src2_is_imm,
    input  logic                in_gpr_we,
    input  logic                in_load_signed,
    input  exu_pkg::mem_size_e  in_mem_size,
    output logic                redirect_valid,
    output exu_pkg::word_t      redirect_pc,
    input  logic                redirect_ack,
    output logic                wb_valid,
    output exu_pkg::reg_idx_t   wb_rd,
    output exu_pkg::word_t      wb_data,
    output logic                halt
);
    exu_pkg::uop_t  uop;
    exu_pkg::word_t rs1_data;
    exu_pkg::word_t rs2_data;

    ex_mem_if u_ex_mem ();
    wb_if     u_wb ();

    assign uop.uop_class   = in_class;
    assign uop.alu_op      = in_alu_op;
    assign uop.rd          = in_rd;
    assign uop.rs1         = in_rs1;
    assign uop.rs2         = in_rs2;
    assign uop.imm         = in_imm;
    assign uop.pc          = in_pc;
    assign uop.src1_is_pc  = in_src1_is_pc;
    assign uop.src2_is_imm = in_src2_is_imm;
    assign uop.gpr_we      = in_gpr_we;
    assign uop.load_signed = in_load_signed;
    assign uop.mem_size    = in_mem_size;

    exu u_exu (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_uop         (uop),
        .in_ready       (in_ready),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_ack   (redirect_ack),
        .halt           (halt),
        .mem            (u_ex_mem.exu_side),
        .wb             (u_wb.bypass_side)
    );

    lsu u_lsu (
        .clk (clk),
        .rst (rst),
        .mem (u_ex_mem.lsu_side),
        .wb  (u_wb.producer)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_idx  (in_rs1),
        .rs2_idx  (in_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (u_wb.regfile_side)
    );

    assign wb_valid = u_wb.valid;
    assign wb_rd    = u_wb.rd;
    assign wb_data  = u_wb.data;

endmodule

// File: verification/exec_core_assert.sv
`timescale 1ns/1ps

module exec_core_assert (
    input logic              clk,
    input logic              rst,
    input logic              wb_valid,
    input exu_pkg::reg_idx_t wb_rd,
    input logic              redirect_valid,
    input logic              redirect_ack,
    input exu_pkg::word_t    x0_value
);
    int fail_count = 0;

    wb_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wb_valid))
        else begin
            fail_count++;
            $error("wb_valid is unknown");
        end

    // a redirect is held until the issuer acknowledges it.
    redirect_held: assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ack |=> redirect_valid)
        else begin
            fail_count++;
            $error("redirect_valid dropped without redirect_ack");
        end

    // the register file drops a writeback aimed at x0.
    x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
        wb_valid && wb_rd == '0 |=> x0_value == '0)
        else begin
            fail_count++;
            $error("a write to register zero changed its stored value");
        end
endmodule

bind exec_core exec_core_assert u_assert (
    .clk            (clk),
    .rst            (rst),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .redirect_valid (redirect_valid),
    .redirect_ack   (redirect_ack),
    .x0_value       (u_regfile.regs[0])
);

// File: verification/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;
    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    exu_pkg::uop_class_e in_class;
    exu_pkg::alu_op_e    in_alu_op;
    exu_pkg::reg_idx_t   in_rd;
    exu_pkg::reg_idx_t   in_rs1;
    exu_pkg::reg_idx_t   in_rs2;
    exu_pkg::word_t      in_imm;
    exu_pkg::word_t      in_pc;
    logic                in_src1_is_pc;
    logic                in_src2_is_imm;
    logic                in_gpr_we;
    logic                in_load_signed;
    exu_pkg::mem_size_e  in_mem_size;
    logic                redirect_valid;
    exu_pkg::word_t      redirect_pc;
    logic                redirect_ack;
    logic                wb_valid;
    exu_pkg::reg_idx_t   wb_rd;
    exu_pkg::word_t      wb_data;
    logic                halt;

    integer            fd;
    logic [31:0]       lfsr_state;
    logic [31:0]       v [16]; // one parsed vector line, columns as in the file.
    exu_pkg::reg_idx_t exp_rd_q [$];
    exu_pkg::word_t    exp_data_q [$];

    exec_core UUT (.*);

    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_wb(input exu_pkg::reg_idx_t exp_rd, input exu_pkg::word_t exp_data);
        if (wb_rd !== exp_rd)
            fail_run($sformatf("** Error wb_rd: expected %h, got %h", exp_rd, wb_rd));
        else if (wb_data !== exp_data)
            fail_run($sformatf("** Error wb_data: expected %h, got %h", exp_data, wb_data));
    endtask

    task automatic check_redirect(input exu_pkg::word_t exp_pc);
        if (redirect_pc !== exp_pc)
            fail_run($sformatf("** Error redirect_pc: expected %h, got %h", exp_pc, redirect_pc));
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic take_bit();
        take_bit   = lfsr_state[0];
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
    endfunction

    task automatic read_vector(output bit got);
        string line;
        int    n;
        got = 1'b0;
        while (!got && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                            v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                if (n != 16)
                    fail_run("a line of the vector file has the wrong number of columns");
                else
                    got = 1'b1;
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance.
    task automatic issue_vector(input bit expect_live);
        int cnt;
        in_class       = exu_pkg::uop_class_e'(v[0][3:0]);
        in_alu_op      = exu_pkg::alu_op_e'(v[1][4:0]);
        in_rd          = v[2][3:0];
        in_rs1         = v[3][3:0];
        in_rs2         = v[4][3:0];
        in_imm         = v[5];
        in_pc          = v[6];
        in_src1_is_pc  = v[7][0];
        in_src2_is_imm = v[8][0];
        in_gpr_we      = v[9][0];
        in_load_signed = v[10][0];
        in_mem_size    = exu_pkg::mem_size_e'(v[11][1:0]);
        in_valid       = 1'b1;
        cnt = 0;
        #1;
        while (!in_ready) begin
            if (cnt == 200) begin
                fail_run("in_ready stayed low for 200 cycles");
            end else begin
                @(negedge clk);
                #1;
                cnt++;
            end
        end
        if (expect_live && v[12][0]) begin
            exp_rd_q.push_back(v[13][3:0]);
            exp_data_q.push_back(v[14]);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic serve_redirect();
        int cnt;
        bit got;
        cnt = 0;
        while (!redirect_valid) begin
            if (cnt == 200) begin
                fail_run("redirect_valid did not rise within 200 cycles");
            end else begin
                @(negedge clk);
                cnt++;
            end
        end
        check_redirect(v[15]);
        read_vector(got);
        if (!got) begin
            fail_run("the vector file has no wrong-path line after a redirect");
        end else begin
            issue_vector(1'b0); // still under the redirect, so it must be squashed.
            redirect_ack = 1'b1;
            @(negedge clk);
            redirect_ack = 1'b0;
        end
    endtask

    task automatic wait_halt();
        int cnt;
        cnt = 0;
        while (!halt) begin
            if (cnt == 200) begin
                fail_run("halt did not rise after the ebreak");
            end else begin
                @(negedge clk);
                cnt++;
            end
        end
    endtask

    task automatic drain_and_finish();
        int cnt;
        cnt = 0;
        while (exp_rd_q.size() != 0 && cnt < 200) begin
            @(negedge clk);
            cnt++;
        end
        if (exp_rd_q.size() != 0) begin
            fail_run("expected writebacks never arrived");
        end else if (UUT.u_assert.fail_count != 0) begin
            fail_run("an assertion of the bound checker failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    endtask

    task automatic run_vectors();
        bit got;
        bit halted;
        int gap;
        halted = 1'b0;
        read_vector(got);
        while (got && !halted) begin
            gap = take_bit();
            gap = gap * 2 + take_bit();
            repeat (gap) @(negedge clk);
            issue_vector(1'b1);
            if (v[12][1]) serve_redirect();
            if (v[12][2]) begin
                wait_halt();
                halted = 1'b1;
            end else begin
                read_vector(got);
            end
        end
        if (halted) drain_and_finish();
        else fail_run("the vector file ended before the ebreak");
    endtask

    // writebacks are compared in program order.
    always @(negedge clk) begin : wb_monitor
        exu_pkg::reg_idx_t rd;
        exu_pkg::word_t    data;
        if (UUT.u_assert.fail_count != 0) begin
            fail_run("an assertion of the bound checker failed");
        end else if (!rst && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                fail_run("a writeback arrived with none expected");
            end else begin
                rd   = exp_rd_q.pop_front();
                data = exp_data_q.pop_front();
                check_wb(rd, data);
            end
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_class       = exu_pkg::UOP_ALU;
        in_alu_op      = exu_pkg::ALU_ADD;
        in_rd          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        in_imm         = '0;
        in_pc          = '0;
        in_src1_is_pc  = 1'b0;
        in_src2_is_imm = 1'b0;
        in_gpr_we      = 1'b0;
        in_load_signed = 1'b0;
        in_mem_size    = exu_pkg::MEM_NONE;
        redirect_ack   = 1'b0;
        lfsr_state     = 32'h8af88012;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("verification/exec_core_vectors.txt", "r");
        if (fd == 0) fail_run("cannot open the vector file");
        else run_vectors();
    end

endmodule

// File: verification/exec_core_vectors.txt
# class aluop rd rs1 rs2 imm pc src1_is_pc src2_is_imm gpr_we load_signed mem_size
# kind(bit0 wb, bit1 redirect, bit2 halt) exp_rd exp_wb_data exp_redirect_pc
0 0 1 0 0 00000005 00000000 0 1 1 0 0 1 1 00000005 00000000
0 0 2 0 0 fffffffd 00000004 0 1 1 0 0 1 2 fffffffd 00000000
0 3 3 2 1 00000000 00000008 0 0 1 0 0 1 3 00000001 00000000
0 4 4 2 1 00000000 0000000c 0 0 1 0 0 1 4 00000000 00000000
0 7 5 2 0 00000001 00000010 0 1 1 0 0 1 5 fffffffe 00000000
0 6 6 2 0 00000004 00000014 0 1 1 0 0 1 6 0fffffff 00000000
0 2 7 1 0 00000003 00000018 0 1 1 0 0 1 7 00000028 00000000
0 a 8 0 0 12345000 0000001c 0 1 1 0 0 1 8 12345000 00000000
0 5 9 8 7 00000000 00000020 0 0 1 0 0 1 9 12345028 00000000
0 8 a 9 1 00000000 00000024 0 0 1 0 0 1 a 1234502d 00000000
0 1 b a 7 00000000 00000028 0 0 1 0 0 1 b 12345005 00000000
0 0 0 1 1 00000000 0000002c 0 0 1 0 0 1 0 0000000a 00000000
0 0 c 0 1 00000000 00000030 0 0 1 0 0 1 c 00000005 00000000
4 0 0 0 8 00000040 00000034 0 1 0 0 3 0 0 00000000 00000000
4 0 0 0 2 00000041 00000038 0 1 0 0 1 0 0 00000000 00000000
4 0 0 0 1 00000042 0000003c 0 1 0 0 2 0 0 00000000 00000000
3 0 d 0 0 00000040 00000040 0 1 1 0 3 1 d 0005fd00 00000000
0 0 e d 1 00000000 00000044 0 0 1 0 0 1 e 0005fd05 00000000
3 0 f 0 0 00000041 00000048 0 1 1 1 1 1 f fffffffd 00000000
3 0 d 0 0 00000041 0000004c 0 1 1 0 1 1 d 000000fd 00000000
3 0 c 0 0 00000040 00000050 0 1 1 1 2 1 c fffffd00 00000000
0 0 3 c d 00000000 00000054 0 0 1 0 0 1 3 fffffdfd 00000000
1 c 0 1 1 00000010 00000058 0 0 0 0 0 0 0 00000000 00000000
1 d 0 2 1 00000020 0000005c 0 0 0 0 0 2 0 00000000 0000007c
0 0 9 0 0 00000077 00000060 0 1 1 0 0 0 0 00000000 00000000
1 10 0 2 1 fffffff8 0000007c 0 0 0 0 0 2 0 00000000 00000074
0 0 1 0 0 00000099 00000080 0 1 1 0 0 0 0 00000000 00000000
2 0 4 0 0 00000100 00000074 1 1 1 0 0 3 4 00000078 00000174
0 0 7 0 0 00000011 00000078 0 1 1 0 0 0 0 00000000 00000000
2 0 5 0 0 00000178 00000174 0 1 1 0 0 1 5 00000178 00000000
2 0 6 5 0 00000009 00000178 0 1 1 0 0 3 6 0000017c 00000180
0 0 7 0 0 00000001 0000017c 0 1 1 0 0 0 0 00000000 00000000
0 0 1 0 0 00000200 00000180 0 1 1 0 0 1 1 00000200 00000000
5 0 7 1 0 00000305 00000184 0 0 1 0 0 1 7 00000000 00000000
6 0 8 0 0 00000305 00000188 0 0 1 0 0 1 8 00000200 00000000
6 0 9 1 0 00000300 0000018c 0 0 1 0 0 1 9 00000000 00000000
5 0 a 0 0 00000300 00000190 0 0 1 0 0 1 a 00000200 00000000
7 0 0 0 0 00000000 00000194 0 0 0 0 0 2 0 00000000 00000200
0 0 b 0 0 00000005 00000198 0 1 1 0 0 0 0 00000000 00000000
6 0 b 0 0 00000341 00000200 0 0 1 0 0 1 b 00000194 00000000
8 0 0 0 0 00000000 00000204 0 0 0 0 0 2 0 00000000 00000194
0 0 b 0 0 00000007 00000208 0 1 1 0 0 0 0 00000000 00000000
9 0 0 0 0 00000000 00000198 0 0 0 0 0 4 0 00000000 00000000

// File: vlog.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_if.sv
verilog/alu.sv
verilog/regfile.sv
verilog/exu.sv
verilog/lsu.sv
verilog/exec_core.sv
verification/exec_core_assert.sv
verification/exec_core_tb.sv

// File: Bender.yml
package:
  name: exec_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exu_pkg.sv
      - verilog/exu_if.sv
      - verilog/alu.sv
      - verilog/regfile.sv
      - verilog/exu.sv
      - verilog/lsu.sv
      - verilog/exec_core.sv
  - target: test
    files:
      - verification/exec_core_assert.sv
      - verification/exec_core_tb.sv
